// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_can_rx
FILELIST = sources.f
LOG      = sim.log
FAIL_MSG = Some tests failed

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	cat $(LOG)
	! grep -q "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/can_rx_sva.sv ====
`timescale 1ns/1ns
`include "can_params.svh"

module can_rx_sva
	import can_pkg::*;
(
	input logic                     clock,
	input logic                     reset,
	input logic                     record_req,
	input logic                     record_ack,
	input can_id_u                  out_id,
	input logic                     out_ide,
	input logic                     out_rtr,
	input logic [`CAN_DLC_LEN-1:0]  out_dlc,
	input logic [`CAN_DATA_LEN-1:0] out_data,
	input can_err_e                 out_error
);

	// ========================================
	// Record handshake
	// ========================================

	// Offer held, record frozen until ack
	req_held: assert property (@(posedge clock) disable iff (reset)
		record_req && !record_ack |=> record_req && $stable(out_id) && $stable(out_ide)
			&& $stable(out_rtr) && $stable(out_dlc) && $stable(out_data)
			&& $stable(out_error))
		else $error("record_req or the record changed before record_ack");

	// New offer only once ack is low
	no_rise_on_ack: assert property (@(posedge clock) disable iff (reset)
		!record_req && record_ack |=> !record_req)
		else $error("record_req rose while record_ack was high");

	req_low_in_reset: assert property (@(posedge clock) reset |-> !record_req)
		else $error("record_req high during reset");

endmodule

bind can_record_port can_rx_sva u_can_rx_sva (
	.clock      (clock),
	.reset      (reset),
	.record_req (record_req),
	.record_ack (record_ack),
	.out_id     (out_id),
	.out_ide    (out_ide),
	.out_rtr    (out_rtr),
	.out_dlc    (out_dlc),
	.out_data   (out_data),
	.out_error  (out_error)
);

// ==== bench/tb_can_rx.sv ====
`timescale 1ns/1ns
`include "can_params.svh"

module tb_can_rx
	import can_pkg::*;
();

	localparam int ROWS        = 15;
	localparam int F_NONE      = 0;
	localparam int F_STUFF     = 1;    // Equal bit where a stuff bit belongs
	localparam int F_CRC       = 2;    // Last CRC bit inverted
	localparam int F_DELIM     = 3;    // Dominant CRC delimiter
	localparam int F_ACK       = 4;    // Nobody drives the ACK slot
	localparam int REQ_WAIT    = 1000; // Longer than any frame in clocks
	localparam int CYCLE_LIMIT = 2 * ROWS * 200 * 4;

	// ========================================
	// Stimulus table
	// ========================================

	// Columns: extended, remote, DLC, fault, ack delay and ack hold in clocks
	localparam int STIM [ROWS][5] = '{
		'{0, 0,  0, F_NONE,    0},
		'{0, 0,  3, F_NONE,    5},
		'{0, 1,  4, F_NONE,    2},   // Remote, no data bytes
		'{1, 0,  8, F_NONE,    7},
		'{1, 1,  0, F_NONE,    1},
		'{0, 0, 12, F_NONE,    3},   // DLC above 8 reads as 8
		'{0, 0,  2, F_STUFF,   4},
		'{1, 0,  5, F_NONE,    0},
		'{0, 0,  8, F_CRC,     2},
		'{0, 0,  1, F_NONE,    3},
		'{1, 0,  6, F_DELIM,   1},
		'{1, 0,  7, F_NONE,    2},
		'{0, 0,  4, F_ACK,     0},
		'{0, 0,  8, F_NONE,    6},
		'{1, 0,  2, F_NONE,  360}    // Next record lands while ack is still high
	};

	logic                     clock = 1'b0;
	logic                     reset;
	logic                     rx_bit;
	logic                     sample_point;
	logic                     record_ack;
	logic                     record_req;
	can_id_u                  out_id;
	logic                     out_ide;
	logic                     out_rtr;
	logic [`CAN_DLC_LEN-1:0]  out_dlc;
	logic [`CAN_DATA_LEN-1:0] out_data;
	can_err_e                 out_error;
	logic                     overrun;

	logic [15:0]              lfsr = 16'd58865;
	bit                       raw[$];        // Frame bits before stuffing
	bit                       stream[$];     // Bits as they go on the bus
	int                       err_count = 0;
	int                       check_count = 0;
	int                       record_count = 0;
	int                       cycle_count = 0;
	logic                     req_prev = 1'b0;
	int                       errors_before;
	int                       records_before;
	int                       row_fault;
	logic [`CAN_ID_LEN-1:0]   exp_id;
	logic                     exp_ide;
	logic                     exp_rtr;
	logic [`CAN_DLC_LEN-1:0]  exp_dlc;
	logic [`CAN_DATA_LEN-1:0] exp_data;
	can_err_e                 exp_err;
	logic [`CAN_ID_LEN-1:0]   spare_id;
	logic [`CAN_DATA_LEN-1:0] spare_data;

	can_rx_top u_can_rx_top (
		.clock        (clock),
		.reset        (reset),
		.rx_bit       (rx_bit),
		.sample_point (sample_point),
		.record_ack   (record_ack),
		.record_req   (record_req),
		.out_id       (out_id),
		.out_ide      (out_ide),
		.out_rtr      (out_rtr),
		.out_dlc      (out_dlc),
		.out_data     (out_data),
		.out_error    (out_error),
		.overrun      (overrun)
	);

	always #5 clock = ~clock;

	// Counts offers, one per rising record_req
	always @(posedge clock)
	begin
		req_prev <= record_req;
		if (record_req && !req_prev)
			record_count <= record_count + 1;
	end

	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == CYCLE_LIMIT)
		begin
			$display("Timeout: run still busy after %0d clocks", CYCLE_LIMIT);
			$display("Some tests failed");
			$finish;
		end
	end

	// ========================================
	// Helpers
	// ========================================

	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);   // Galois taps
	endfunction

	task automatic take_random(input int n, output logic [63:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[62:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// CAN CRC-15 per bit, as in the bus specification
	function automatic logic [`CAN_CRC_LEN-1:0] crc_update(input logic [`CAN_CRC_LEN-1:0] crc,
		input bit b);
		logic feedback;
		feedback = b ^ crc[`CAN_CRC_LEN-1];
		crc = crc << 1;
		if (feedback)
			crc = crc ^ `CAN_CRC_POLY;
		return crc;
	endfunction

	task automatic push_field(input logic [63:0] value, input int width);
		for (int i = width - 1; i >= 0; i--)
			raw.push_back(value[i]);                 // MSB first on the bus
	endtask

	function automatic string fault_name(input int fault);
		case (fault)
			F_STUFF: return "stuff";
			F_CRC:   return "crc flip";
			F_DELIM: return "crc delimiter";
			F_ACK:   return "ack slot";
			default: return "clean";
		endcase
	endfunction

	task automatic compare_value(input string name, input logic [63:0] got,
		input logic [63:0] want);
		check_count++;
		if (got !== want)
		begin
			$display("FAIL %0t %s got %0h expected %0h", $time, name, got, want);
			err_count++;
		end
	endtask

	// ========================================
	// Serializer
	// ========================================

	// Appends idle, stuffed SOF..CRC and the fixed tail to stream
	task automatic build_frame(input bit ext, input bit rtr, input logic [3:0] dlc,
		input int fault, output logic [`CAN_ID_LEN-1:0] id, output logic [63:0] data);
		logic [63:0]             v;
		logic [`CAN_CRC_LEN-1:0] crc;
		int                      nbytes;
		int                      run;
		bit                      last;
		bit                      injected;
		raw.delete();
		take_random(ext ? `CAN_ID_LEN : `CAN_ID_A_LEN, v);
		id = ext ? v[`CAN_ID_LEN-1:0] : {v[`CAN_ID_A_LEN-1:0], `CAN_ID_B_LEN'(0)};
		if (fault == F_STUFF)
			id[`CAN_ID_LEN-1 -: 4] = 4'd0;                 // SOF plus 4 zeros, stuff point
		push_field(64'd0, 1);                            // SOF
		push_field(64'(id[`CAN_ID_LEN-1 -: `CAN_ID_A_LEN]), `CAN_ID_A_LEN);
		if (ext)
		begin
			push_field(64'd3, 2);                          // SRR and IDE recessive
			push_field(64'(id[`CAN_ID_B_LEN-1:0]), `CAN_ID_B_LEN);
			push_field(64'(rtr), 1);
			push_field(64'd0, 2);                          // r1 r0
		end
		else
		begin
			push_field(64'(rtr), 1);
			push_field(64'd0, 2);                          // IDE r0
		end
		push_field(64'(dlc), `CAN_DLC_LEN);
		nbytes = rtr ? 0 : ((dlc > 4'(`CAN_MAX_BYTES)) ? `CAN_MAX_BYTES : int'(dlc));
		data = '0;
		for (int i = 0; i < nbytes; i++)
		begin
			take_random(8, v);
			data = {data[55:0], v[7:0]};                 // Right-aligned, first byte high
			push_field(v, 8);
		end
		crc = '0;
		foreach (raw[i])
			crc = crc_update(crc, raw[i]);
		if (fault == F_CRC)
			crc[0] = ~crc[0];
		push_field(64'(crc), `CAN_CRC_LEN);
		repeat (`CAN_IDLE_RUN + 1) stream.push_back(1'b1);
		last = 1'b1;
		run = 0;
		injected = 1'b0;
		foreach (raw[i])
		begin
			stream.push_back(raw[i]);
			if (raw[i] == last)
				run++;
			else
			begin
				last = raw[i];
				run = 1;
			end
			if (run == `CAN_STUFF_RUN)
			begin
				if (fault == F_STUFF && !injected)
					injected = 1'b1;                         // Sixth equal bit
				else
					last = ~last;
				stream.push_back(last);
				run = 1;                                     // Stuff bit opens next run
			end
		end
		stream.push_back(fault == F_DELIM ? 1'b0 : 1'b1);  // CRC delimiter
		stream.push_back(fault == F_ACK ? 1'b1 : 1'b0);    // ACK slot
		repeat (1 + `CAN_EOF_LEN) stream.push_back(1'b1);  // ACK delimiter, EOF
	endtask

	// One bit per four clocks, strobe on the first
	task automatic send_stream();
		foreach (stream[i])
		begin
			@(negedge clock);
			rx_bit = stream[i];
			sample_point = 1'b1;
			@(negedge clock);
			sample_point = 1'b0;
			repeat (2) @(negedge clock);
		end
	endtask

	// ========================================
	// Consumer
	// ========================================

	task automatic consume_record(input int delay);
		int waited;
		waited = 0;
		while (record_req !== 1'b1 && waited < REQ_WAIT)
		begin
			@(negedge clock);
			waited++;
		end
		if (record_req !== 1'b1)
		begin
			$display("No record was offered within %0d clocks", REQ_WAIT);
			err_count++;
		end
		else
		begin
			compare_value("out_error", 64'(out_error), 64'(exp_err));
			if (exp_err == ERR_NONE)
			begin
				compare_value("out_ide", 64'(out_ide), 64'(exp_ide));
				compare_value("out_rtr", 64'(out_rtr), 64'(exp_rtr));
				compare_value("out_dlc", 64'(out_dlc), 64'(exp_dlc));
				compare_value("out_data", out_data, exp_data);
				compare_value("out_id.full", 64'(out_id.full), 64'(exp_id));
				compare_value("out_id.parts.base_id", 64'(out_id.parts.base_id),
					64'(exp_id[`CAN_ID_LEN-1 -: `CAN_ID_A_LEN]));
				compare_value("out_id.parts.ext_id", 64'(out_id.parts.ext_id),
					64'(exp_id[`CAN_ID_B_LEN-1:0]));
			end
			repeat (delay) @(negedge clock);
			record_ack = 1'b1;
			waited = 0;
			while (record_req === 1'b1 && waited < REQ_WAIT)
			begin
				@(negedge clock);
				waited++;
			end
			if (record_req === 1'b1)
			begin
				$display("record_req did not drop after record_ack was raised");
				err_count++;
			end
			repeat (delay) @(negedge clock);            // Slow consumer keeps ack high
			record_ack = 1'b0;
		end
	endtask

	// ========================================
	// Main sequence
	// ========================================

	initial
	begin
		reset = 1'b1;
		rx_bit = 1'b1;                                   // Idle bus is recessive
		sample_point = 1'b0;
		record_ack = 1'b0;
		repeat (10) @(negedge clock);
		reset = 1'b0;
		for (int r = 0; r < ROWS; r++)
		begin
			errors_before = err_count;
			records_before = record_count;
			row_fault = STIM[r][3];
			exp_ide = (STIM[r][0] != 0);
			exp_rtr = (STIM[r][1] != 0);
			exp_dlc = 4'(STIM[r][2]);
			if (exp_dlc > 4'(`CAN_MAX_BYTES))
				exp_dlc = 4'(`CAN_MAX_BYTES);
			case (row_fault)
				F_STUFF: exp_err = ERR_STUFF;
				F_CRC:   exp_err = ERR_CRC;
				F_DELIM: exp_err = ERR_FORM;
				F_ACK:   exp_err = ERR_ACK;
				default: exp_err = ERR_NONE;
			endcase
			stream.delete();
			build_frame(exp_ide, exp_rtr, 4'(STIM[r][2]), row_fault, exp_id, exp_data);
			if (r == ROWS - 1)
				build_frame(1'b0, 1'b0, 4'd8, F_NONE, spare_id, spare_data);   // Gets dropped
			fork
				send_stream();
				consume_record(STIM[r][4]);
			join
			compare_value("record count", 64'(record_count - records_before), 64'd1);
			compare_value("overrun", 64'(overrun), (r == ROWS - 1) ? 64'd1 : 64'd0);
			$display("Row %0d %s %s dlc %0d %s: %s", r, exp_ide ? "ext" : "base",
				exp_rtr ? "remote" : "data", STIM[r][2], fault_name(row_fault),
				(err_count == errors_before) ? "ok" : "mismatch");
		end
		$display("%0d rows, %0d checks, %0d errors", ROWS, check_count, err_count);
		if (err_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// ==== logic/can_crc.sv ====
`timescale 1ns/1ns
`include "can_params.svh"

module can_crc (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    crc_clear,     // Start of frame
	input  logic                    crc_enable,    // One accepted protected bit
	input  logic                    rx_bit,
	output logic [`CAN_CRC_LEN-1:0] crc_value
);

	logic crc_next;    // Feedback into the polynomial taps

	assign crc_next = rx_bit ^ crc_value[`CAN_CRC_LEN-1];

	// ========================================
	// CRC-15 shift register
	// ========================================

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			crc_value <= '0;
		else if (crc_clear)
			crc_value <= '0;                                 // CAN starts from zero
		else if (crc_enable)
			crc_value <= {crc_value[`CAN_CRC_LEN-2:0], 1'b0}
				^ (`CAN_CRC_POLY & {`CAN_CRC_LEN{crc_next}});
	end

endmodule

// ==== logic/can_destuff.sv ====
`timescale 1ns/1ns
`include "can_params.svh"

module can_destuff (
	input  logic clock,
	input  logic reset,
	input  logic sample_point,
	input  logic rx_bit,
	input  logic stuff_region,    // From the sequencer
	output logic bit_valid,       // Sampled bit carries data
	output logic stuff_error      // Rule broken in this sample
);

	// Last sampled bits, newest in bit 0
	logic [`CAN_STUFF_RUN-1:0] history;
	logic                      run_full;    // History is one long run
	logic                      same_bit;    // New bit extends the run

	// ========================================
	// Run detection
	// ========================================

	assign run_full = (&history) | (~|history);
	assign same_bit = (rx_bit == history[0]);

	// Opposite bit after a full run is the stuff bit itself
	assign bit_valid = ~(stuff_region & run_full & ~same_bit);

	// Equal bit after a full run is never allowed in the region
	assign stuff_error = sample_point & stuff_region & run_full & same_bit;

	// ========================================
	// Bit history
	// ========================================

	// Every sampled bit enters, stuff bits and SOF included,
	// since a stuff bit starts the next run
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			history <= '1;                                   // Idle bus is recessive
		else if (sample_point)
			history <= {history[`CAN_STUFF_RUN-2:0], rx_bit};
	end

endmodule

// ==== logic/can_field_sequencer.sv ====
`timescale 1ns/1ns
`include "can_params.svh"

module can_field_sequencer
	import can_pkg::*;
(
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     sample_point,
	input  logic                     rx_bit,
	input  logic                     bit_valid,      // Not a stuff bit
	input  logic                     stuff_error,
	input  logic [`CAN_CRC_LEN-1:0]  crc_value,      // Computed over SOF to data
	output logic                     stuff_region,
	output logic                     crc_clear,
	output logic                     crc_enable,
	output logic                     record_valid,   // One clock per record
	output can_id_u                  record_id,
	output logic                     record_ide,
	output logic                     record_rtr,
	output logic [`CAN_DLC_LEN-1:0]  record_dlc,
	output logic [`CAN_DATA_LEN-1:0] record_data,
	output can_err_e                 record_error
);

	can_state_e               state;
	can_state_e               state_next;
	logic [5:0]               bit_cnt;       // Shared by all multi-bit fields
	logic [5:0]               cnt_next;
	logic                     take;          // Data bit sampled this clock
	logic                     field_end;     // Last bit of the current field
	logic                     err_hit;
	can_err_e                 err_code;
	logic                     frame_done;    // Last EOF bit accepted
	logic                     srr_rtr;       // RTR of a base frame, SRR of an extended one
	logic [`CAN_CRC_LEN-1:0]  crc_rx;        // CRC field as received
	logic [`CAN_DLC_LEN-1:0]  dlc_raw;
	logic [`CAN_DLC_LEN-1:0]  dlc_clamped;
	logic [`CAN_DLC_LEN-1:0]  dlc_m1;
	logic [5:0]               data_last;     // Index of last data bit

	assign take = sample_point & bit_valid;

	// Region also covers CRC_DELIM, which may still see the stuff bit after the CRC
	assign stuff_region = state inside {[ID_A:CRC_DELIM]};
	assign crc_clear    = take & (state == IDLE) & ~rx_bit;
	assign crc_enable   = take & (state inside {[ID_A:DATA]});

	// ========================================
	// Field lengths
	// ========================================

	assign dlc_raw     = {record_dlc[`CAN_DLC_LEN-2:0], rx_bit};
	assign dlc_clamped = (dlc_raw > 4'(`CAN_MAX_BYTES)) ? 4'(`CAN_MAX_BYTES) : dlc_raw;
	assign dlc_m1      = record_dlc - 4'd1;
	assign data_last   = {dlc_m1[2:0], 3'b111};                  // 8*DLC-1

	always_comb
	begin
		case (state)
			ID_A:    field_end = (bit_cnt == 6'(`CAN_ID_A_LEN - 1));
			ID_B:    field_end = (bit_cnt == 6'(`CAN_ID_B_LEN - 1));
			DLC:     field_end = (bit_cnt == 6'(`CAN_DLC_LEN - 1));
			DATA:    field_end = (bit_cnt == data_last);
			CRC:     field_end = (bit_cnt == 6'(`CAN_CRC_LEN - 1));
			EOF:     field_end = (bit_cnt == 6'(`CAN_EOF_LEN - 1));
			RECOVER: field_end = (bit_cnt == 6'(`CAN_IDLE_RUN - 1));
			default: field_end = 1'b1;                         // Single-bit fields
		endcase
	end

	// ========================================
	// Next state and error detection
	// ========================================

	always_comb
	begin
		state_next = state;
		cnt_next   = bit_cnt;
		err_hit    = 1'b0;
		err_code   = ERR_NONE;
		frame_done = 1'b0;
		if (stuff_error)
		begin
			err_hit  = 1'b1;
			err_code = ERR_STUFF;
		end
		else if (take)
		begin
			cnt_next = field_end ? 6'd0 : bit_cnt + 6'd1;
			case (state)
				IDLE:      if (!rx_bit) state_next = ID_A;       // Dominant SOF
				ID_A:      if (field_end) state_next = SRR_RTR;
				SRR_RTR:   state_next = IDE;
				IDE:
				begin
					if (rx_bit && !srr_rtr)                     // SRR must be recessive
					begin
						err_hit  = 1'b1;
						err_code = ERR_FORM;
					end
					else
						state_next = rx_bit ? ID_B : R0;
				end
				ID_B:      if (field_end) state_next = RTR;
				RTR:       state_next = R1;
				R1:        state_next = R0;
				R0:        state_next = DLC;
				DLC:
				begin
					if (field_end)
						state_next = (dlc_clamped == '0 || record_rtr) ? CRC : DATA;
				end
				DATA:      if (field_end) state_next = CRC;
				CRC:       if (field_end) state_next = CRC_DELIM;
				CRC_DELIM:
				begin
					if (!rx_bit)
					begin
						err_hit  = 1'b1;
						err_code = ERR_FORM;
					end
					else if (crc_value != crc_rx)
					begin
						err_hit  = 1'b1;
						err_code = ERR_CRC;
					end
					else
						state_next = ACK_SLOT;
				end
				ACK_SLOT:
				begin
					if (rx_bit)                                  // No receiver answered
					begin
						err_hit  = 1'b1;
						err_code = ERR_ACK;
					end
					else
						state_next = ACK_DELIM;
				end
				ACK_DELIM, EOF:
				begin
					if (!rx_bit)
					begin
						err_hit  = 1'b1;
						err_code = ERR_FORM;
					end
					else if (state == ACK_DELIM)
						state_next = EOF;
					else if (field_end)
					begin
						frame_done = 1'b1;
						state_next = IDLE;
					end
				end
				RECOVER:
				begin
					if (!rx_bit)
						cnt_next = 6'd0;                         // Run broken, count again
					else if (field_end)
						state_next = IDLE;
				end
				default:   state_next = IDLE;
			endcase
		end
		if (err_hit)
		begin
			state_next = RECOVER;
			cnt_next   = 6'd0;
		end
	end

	// ========================================
	// Control registers
	// ========================================

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state        <= IDLE;
			bit_cnt      <= 6'd0;
			record_valid <= 1'b0;
			record_error <= ERR_NONE;
		end
		else
		begin
			state        <= state_next;
			bit_cnt      <= cnt_next;
			record_valid <= err_hit | frame_done;
			if (err_hit | frame_done)
				record_error <= err_code;
		end
	end

	// ========================================
	// Field assembly
	// ========================================

	always_ff @(posedge clock)
	begin
		if (take && !stuff_error)
		begin
			case (state)
				IDLE:
				begin
					if (!rx_bit)                                 // Fresh frame
					begin
						record_id   <= '0;
						record_ide  <= 1'b0;
						record_rtr  <= 1'b0;
						record_dlc  <= '0;
						record_data <= '0;
					end
				end
				ID_A:    record_id.parts.base_id <=
					{record_id.parts.base_id[`CAN_ID_A_LEN-2:0], rx_bit};
				SRR_RTR: srr_rtr <= rx_bit;
				IDE:
				begin
					record_ide <= rx_bit;
					if (!rx_bit)
						record_rtr <= srr_rtr;                   // Base frame RTR
				end
				ID_B:    record_id.parts.ext_id <=
					{record_id.parts.ext_id[`CAN_ID_B_LEN-2:0], rx_bit};
				RTR:     record_rtr <= rx_bit;
				DLC:     record_dlc <= field_end ? dlc_clamped : dlc_raw;
				DATA:    record_data <= {record_data[`CAN_DATA_LEN-2:0], rx_bit};
				CRC:     crc_rx <= {crc_rx[`CAN_CRC_LEN-2:0], rx_bit};
				default: ;
			endcase
		end
	end

endmodule

// ==== logic/can_params.svh ====
`ifndef CAN_PARAMS_SVH
`define CAN_PARAMS_SVH

// ========================================
// Frame field lengths
// ========================================

`define CAN_ID_A_LEN    11          // Base identifier
`define CAN_ID_B_LEN    18          // Identifier extension
`define CAN_ID_LEN      29          // Base plus extension
`define CAN_DLC_LEN     4           // Data length code
`define CAN_MAX_BYTES   8           // Larger DLC values read as 8
`define CAN_DATA_LEN    64          // Payload register width
`define CAN_CRC_LEN     15

// ========================================
// Bit stream rules
// ========================================

`define CAN_CRC_POLY    15'h4599    // x^15+x^14+x^10+x^8+x^7+x^4+x^3+1
`define CAN_STUFF_RUN   5           // Equal bits before a stuff bit
`define CAN_EOF_LEN     7           // Recessive end-of-frame bits
`define CAN_IDLE_RUN    11          // Recessive bits that close error recovery

`endif

// ==== logic/can_pkg.sv ====
`include "can_params.svh"

package can_pkg;

	// Same 29 bits seen flat or as the two identifier fields
	// Base part is received first, so it sits in the upper bits
	typedef union packed {
		logic [`CAN_ID_LEN-1:0] full;
		struct packed {
			logic [`CAN_ID_A_LEN-1:0] base_id;
			logic [`CAN_ID_B_LEN-1:0] ext_id;   // Stays zero in a base frame
		} parts;
	} can_id_u;

	// Result code carried with every record
	typedef enum logic [2:0] {
		ERR_NONE,
		ERR_STUFF,      // Sixth equal bit in the stuffed region
		ERR_FORM,       // Fixed-form bit with the wrong level
		ERR_CRC,        // Received CRC differs from computed one
		ERR_ACK         // Nobody drove the ACK slot
	} can_err_e;

	// Sequencer position inside the frame
	typedef enum logic [3:0] {
		IDLE, ID_A, SRR_RTR, IDE,
		ID_B, RTR, R1, R0,
		DLC, DATA, CRC, CRC_DELIM,
		ACK_SLOT, ACK_DELIM, EOF, RECOVER
	} can_state_e;

endpackage

// ==== logic/can_record_port.sv ====
`timescale 1ns/1ns
`include "can_params.svh"

module can_record_port
	import can_pkg::*;
(
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     record_valid,
	input  can_id_u                  record_id,
	input  logic                     record_ide,
	input  logic                     record_rtr,
	input  logic [`CAN_DLC_LEN-1:0]  record_dlc,
	input  logic [`CAN_DATA_LEN-1:0] record_data,
	input  can_err_e                 record_error,
	input  logic                     record_ack,     // From the consumer
	output logic                     record_req,
	output can_id_u                  out_id,
	output logic                     out_ide,
	output logic                     out_rtr,
	output logic [`CAN_DLC_LEN-1:0]  out_dlc,
	output logic [`CAN_DATA_LEN-1:0] out_data,
	output can_err_e                 out_error,
	output logic                     overrun         // Sticky until reset
);

	logic busy;     // Offering, or waiting for ack to fall
	logic accept;   // Record taken into the holder

	assign busy   = record_req | record_ack;
	assign accept = record_valid & ~busy;

	// ========================================
	// Four-phase handshake
	// ========================================

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			record_req <= 1'b0;
			overrun    <= 1'b0;
		end
		else
		begin
			if (record_req && record_ack)
				record_req <= 1'b0;                              // Ack seen, withdraw
			else if (accept)
				record_req <= 1'b1;                              // Offer new record
			if (record_valid && busy)
				overrun <= 1'b1;                                 // Bus cannot wait, record lost
		end
	end

	// Held stable while record_req is high
	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			out_id    <= record_id;
			out_ide   <= record_ide;
			out_rtr   <= record_rtr;
			out_dlc   <= record_dlc;
			out_data  <= record_data;
			out_error <= record_error;
		end
	end

endmodule

// ==== logic/can_rx_top.sv ====
`timescale 1ns/1ns
`include "can_params.svh"

module can_rx_top
	import can_pkg::*;
(
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     rx_bit,         // Recessive 1, dominant 0
	input  logic                     sample_point,   // One clock per bit
	input  logic                     record_ack,
	output logic                     record_req,
	output can_id_u                  out_id,
	output logic                     out_ide,
	output logic                     out_rtr,
	output logic [`CAN_DLC_LEN-1:0]  out_dlc,
	output logic [`CAN_DATA_LEN-1:0] out_data,
	output can_err_e                 out_error,
	output logic                     overrun
);

	// Decode to execute
	logic                     stuff_region;
	logic                     bit_valid;
	logic                     stuff_error;
	// Execute to CRC
	logic                     crc_clear;
	logic                     crc_enable;
	logic [`CAN_CRC_LEN-1:0]  crc_value;
	// Execute to result
	logic                     record_valid;
	can_id_u                  record_id;
	logic                     record_ide;
	logic                     record_rtr;
	logic [`CAN_DLC_LEN-1:0]  record_dlc;
	logic [`CAN_DATA_LEN-1:0] record_data;
	can_err_e                 record_error;

	can_destuff u_can_destuff (
		.clock        (clock),
		.reset        (reset),
		.sample_point (sample_point),
		.rx_bit       (rx_bit),
		.stuff_region (stuff_region),
		.bit_valid    (bit_valid),
		.stuff_error  (stuff_error)
	);

	can_crc u_can_crc (
		.clock      (clock),
		.reset      (reset),
		.crc_clear  (crc_clear),
		.crc_enable (crc_enable),
		.rx_bit     (rx_bit),
		.crc_value  (crc_value)
	);

	can_field_sequencer u_can_field_sequencer (
		.clock        (clock),
		.reset        (reset),
		.sample_point (sample_point),
		.rx_bit       (rx_bit),
		.bit_valid    (bit_valid),
		.stuff_error  (stuff_error),
		.crc_value    (crc_value),
		.stuff_region (stuff_region),
		.crc_clear    (crc_clear),
		.crc_enable   (crc_enable),
		.record_valid (record_valid),
		.record_id    (record_id),
		.record_ide   (record_ide),
		.record_rtr   (record_rtr),
		.record_dlc   (record_dlc),
		.record_data  (record_data),
		.record_error (record_error)
	);

	can_record_port u_can_record_port (
		.clock        (clock),
		.reset        (reset),
		.record_valid (record_valid),
		.record_id    (record_id),
		.record_ide   (record_ide),
		.record_rtr   (record_rtr),
		.record_dlc   (record_dlc),
		.record_data  (record_data),
		.record_error (record_error),
		.record_ack   (record_ack),
		.record_req   (record_req),
		.out_id       (out_id),
		.out_ide      (out_ide),
		.out_rtr      (out_rtr),
		.out_dlc      (out_dlc),
		.out_data     (out_data),
		.out_error    (out_error),
		.overrun      (overrun)
	);

endmodule

// ==== sources.f ====
+incdir+logic
logic/can_pkg.sv
logic/can_destuff.sv
logic/can_crc.sv
logic/can_field_sequencer.sv
logic/can_record_port.sv
logic/can_rx_top.sv
bench/can_rx_sva.sv
bench/tb_can_rx.sv
